// ==== wt_cache_pkg.sv ====
`default_nettype none

package wt_cache_pkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  // word addresses, one word per line
  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned IDX_W     = 4;
  localparam int unsigned TAG_W     = ADDR_W - IDX_W;
  localparam int unsigned NUM_LINES = 2 ** IDX_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  tag_t;

  //////////////////////////////
  // state encodings
  //////////////////////////////

  // shared by both cache controllers
  typedef enum logic [2:0] {
    C_IDLE,
    C_LOOKUP,
    C_MEM_REQ,
    C_MEM_REL,
    C_CPU_ACK
  } cache_state_e;

  // memory adapter
  typedef enum logic [1:0] {
    A_IDLE,
    A_GRANT_I,
    A_GRANT_D,
    A_RELEASE
  } arb_state_e;

  // last winner of the round robin
  typedef enum logic {
    G_ICACHE,
    G_DCACHE
  } grant_e;

endpackage

`default_nettype wire

// ==== cache_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_mem_if;

  import wt_cache_pkg::*;

  // four-phase req/ack link between a cache and the adapter
  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  logic  ack;
  // valid while ack is high on a read
  word_t rdata;

  // cache side
  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  ack,
    input  rdata
  );

  // adapter side
  modport responder (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

// ==== wt_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_icache (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                flush_i,
  input  wire logic                cpu_req_i,
  input  wire wt_cache_pkg::addr_t cpu_addr_i,
  output logic                     cpu_ack_o,
  output wt_cache_pkg::word_t      cpu_rdata_o,
  output logic                     miss_o,
  cache_mem_if.requester           mem
);

  import wt_cache_pkg::*;

  cache_state_e         state_q;
  logic [NUM_LINES-1:0] valid_q;
  tag_t                 tag_mem [NUM_LINES];
  word_t                data_mem [NUM_LINES];
  addr_t                addr_q;
  word_t                rdata_q;
  logic [IDX_W-1:0]     idx;
  tag_t                 tag;
  logic                 hit;

  // lookup on the latched address
  assign idx = addr_q[IDX_W-1:0];
  assign tag = addr_q[ADDR_W-1:IDX_W];
  assign hit = valid_q[idx] && (tag_mem[idx] == tag);

  assign cpu_ack_o   = (state_q == C_CPU_ACK);
  assign cpu_rdata_o = rdata_q;
  assign miss_o      = (state_q == C_LOOKUP) && !hit;

  // refill reads only
  assign mem.req   = (state_q == C_MEM_REQ);
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q;
  assign mem.wdata = '0;

  //////////////////////////////
  // controller
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= C_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        C_IDLE: begin
          if (cpu_req_i) begin
            state_q <= C_LOOKUP;
          end else if (flush_i) begin
            // invalidate every line at once
            valid_q <= '0;
          end
        end
        C_LOOKUP: begin
          state_q <= hit ? C_CPU_ACK : C_MEM_REQ;
        end
        C_MEM_REQ: begin
          if (mem.ack) begin
            state_q      <= C_MEM_REL;
            valid_q[idx] <= 1'b1;
          end
        end
        C_MEM_REL: begin
          if (!mem.ack) begin
            state_q <= C_CPU_ACK;
          end
        end
        C_CPU_ACK: begin
          if (!cpu_req_i) begin
            state_q <= C_IDLE;
          end
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // arrays and payload
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == C_IDLE && cpu_req_i) begin
      addr_q <= cpu_addr_i;
    end
    if (state_q == C_LOOKUP && hit) begin
      rdata_q <= data_mem[idx];
    end
    // line fill with the returned word
    if (state_q == C_MEM_REQ && mem.ack) begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= mem.rdata;
      rdata_q       <= mem.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== wt_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_dcache (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                cpu_req_i,
  input  wire logic                cpu_we_i,
  input  wire wt_cache_pkg::addr_t cpu_addr_i,
  input  wire wt_cache_pkg::word_t cpu_wdata_i,
  output logic                     cpu_ack_o,
  output wt_cache_pkg::word_t      cpu_rdata_o,
  output logic                     miss_o,
  cache_mem_if.requester           mem
);

  import wt_cache_pkg::*;

  cache_state_e         state_q;
  logic [NUM_LINES-1:0] valid_q;
  tag_t                 tag_mem [NUM_LINES];
  word_t                data_mem [NUM_LINES];
  addr_t                addr_q;
  word_t                wdata_q;
  logic                 we_q;
  word_t                rdata_q;
  logic [IDX_W-1:0]     idx;
  tag_t                 tag;
  logic                 hit;

  assign idx = addr_q[IDX_W-1:0];
  assign tag = addr_q[ADDR_W-1:IDX_W];
  assign hit = valid_q[idx] && (tag_mem[idx] == tag);

  assign cpu_ack_o   = (state_q == C_CPU_ACK);
  assign cpu_rdata_o = rdata_q;
  // read and write misses both count
  assign miss_o      = (state_q == C_LOOKUP) && !hit;

  // every write and every read miss goes out on the link
  assign mem.req   = (state_q == C_MEM_REQ);
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  //////////////////////////////
  // controller
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= C_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        C_IDLE: begin
          if (cpu_req_i) begin
            state_q <= C_LOOKUP;
          end
        end
        C_LOOKUP: begin
          // only a read hit is served locally
          if (!we_q && hit) begin
            state_q <= C_CPU_ACK;
          end else begin
            state_q <= C_MEM_REQ;
          end
        end
        C_MEM_REQ: begin
          if (mem.ack) begin
            state_q <= C_MEM_REL;
            if (!we_q) begin
              valid_q[idx] <= 1'b1;
            end
          end
        end
        C_MEM_REL: begin
          if (!mem.ack) begin
            state_q <= C_CPU_ACK;
          end
        end
        C_CPU_ACK: begin
          if (!cpu_req_i) begin
            state_q <= C_IDLE;
          end
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // arrays and payload
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == C_IDLE && cpu_req_i) begin
      addr_q  <= cpu_addr_i;
      we_q    <= cpu_we_i;
      wdata_q <= cpu_wdata_i;
    end
    if (state_q == C_LOOKUP) begin
      if (we_q) begin
        rdata_q <= wdata_q;
        // write hit keeps the line in step with memory
        if (hit) begin
          data_mem[idx] <= wdata_q;
        end
      end else if (hit) begin
        rdata_q <= data_mem[idx];
      end
    end
    // write miss leaves the arrays alone
    if (state_q == C_MEM_REQ && mem.ack && !we_q) begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= mem.rdata;
      rdata_q       <= mem.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== wt_mem_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_mem_adapter (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  cache_mem_if.responder           ic,
  cache_mem_if.responder           dc,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output wt_cache_pkg::addr_t      mem_addr_o,
  output wt_cache_pkg::word_t      mem_wdata_o,
  input  wire logic                mem_ack_i,
  input  wire wt_cache_pkg::word_t mem_rdata_i
);

  import wt_cache_pkg::*;

  arb_state_e state_q;
  grant_e     last_q;
  logic       pick_ic;

  // icache wins unless only dcache asks, or icache won last time
  assign pick_ic = ic.req && (!dc.req || (last_q == G_DCACHE));

  //////////////////////////////
  // arbiter FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= A_IDLE;
      last_q  <= G_DCACHE;
    end else begin
      case (state_q)
        A_IDLE: begin
          if (pick_ic) begin
            state_q <= A_GRANT_I;
            last_q  <= G_ICACHE;
          end else if (dc.req) begin
            state_q <= A_GRANT_D;
            last_q  <= G_DCACHE;
          end
        end
        // hold until the whole handshake has closed
        A_GRANT_I: begin
          if (!ic.req && !mem_ack_i) begin
            state_q <= A_RELEASE;
          end
        end
        A_GRANT_D: begin
          if (!dc.req && !mem_ack_i) begin
            state_q <= A_RELEASE;
          end
        end
        default: state_q <= A_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // port mux and ack steering
  //////////////////////////////

  always_comb begin
    mem_req_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = '0;
    mem_wdata_o = '0;
    ic.ack      = 1'b0;
    ic.rdata    = '0;
    dc.ack      = 1'b0;
    dc.rdata    = '0;
    case (state_q)
      A_GRANT_I: begin
        mem_req_o   = ic.req;
        mem_we_o    = ic.we;
        mem_addr_o  = ic.addr;
        mem_wdata_o = ic.wdata;
        ic.ack      = mem_ack_i;
        ic.rdata    = mem_rdata_i;
      end
      A_GRANT_D: begin
        mem_req_o   = dc.req;
        mem_we_o    = dc.we;
        mem_addr_o  = dc.addr;
        mem_wdata_o = dc.wdata;
        dc.ack      = mem_ack_i;
        dc.rdata    = mem_rdata_i;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== wt_cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_cache_subsystem (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  // instruction side
  input  wire logic                ic_flush_i,
  input  wire logic                ic_req_i,
  input  wire wt_cache_pkg::addr_t ic_addr_i,
  output logic                     ic_ack_o,
  output wt_cache_pkg::word_t      ic_rdata_o,
  output logic                     ic_miss_o,
  // data side
  input  wire logic                dc_req_i,
  input  wire logic                dc_we_i,
  input  wire wt_cache_pkg::addr_t dc_addr_i,
  input  wire wt_cache_pkg::word_t dc_wdata_i,
  output logic                     dc_ack_o,
  output wt_cache_pkg::word_t      dc_rdata_o,
  output logic                     dc_miss_o,
  // external memory
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output wt_cache_pkg::addr_t      mem_addr_o,
  output wt_cache_pkg::word_t      mem_wdata_o,
  input  wire logic                mem_ack_i,
  input  wire wt_cache_pkg::word_t mem_rdata_i
);

  // cache to adapter links
  cache_mem_if ic_mem ();
  cache_mem_if dc_mem ();

  //////////////////////////////
  // caches
  //////////////////////////////

  wt_icache u_icache (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (ic_flush_i),
    .cpu_req_i   (ic_req_i),
    .cpu_addr_i  (ic_addr_i),
    .cpu_ack_o   (ic_ack_o),
    .cpu_rdata_o (ic_rdata_o),
    .miss_o      (ic_miss_o),
    .mem         (ic_mem.requester)
  );

  wt_dcache u_dcache (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cpu_req_i   (dc_req_i),
    .cpu_we_i    (dc_we_i),
    .cpu_addr_i  (dc_addr_i),
    .cpu_wdata_i (dc_wdata_i),
    .cpu_ack_o   (dc_ack_o),
    .cpu_rdata_o (dc_rdata_o),
    .miss_o      (dc_miss_o),
    .mem         (dc_mem.requester)
  );

  //////////////////////////////
  // memory port
  //////////////////////////////

  wt_mem_adapter u_adapter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ic          (ic_mem.responder),
    .dc          (dc_mem.responder),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

// ==== tb_wt_cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wt_cache_subsystem;

  import wt_cache_pkg::*;

  localparam int TIMEOUT   = 100;
  localparam int MEM_WORDS = 65536;

  logic  clk_i;
  logic  rst_n_i;
  logic  ic_flush_i;
  logic  ic_req_i;
  addr_t ic_addr_i;
  logic  ic_ack_o;
  word_t ic_rdata_o;
  logic  ic_miss_o;
  logic  dc_req_i;
  logic  dc_we_i;
  addr_t dc_addr_i;
  word_t dc_wdata_i;
  logic  dc_ack_o;
  word_t dc_rdata_o;
  logic  dc_miss_o;
  logic  mem_req_o;
  logic  mem_we_o;
  addr_t mem_addr_o;
  word_t mem_wdata_o;
  logic  mem_ack_i;
  word_t mem_rdata_i;

  integer seed = 61;
  int     errors = 0;
  int     mem_txn = 0;
  int     exp_txn = 0;

  // backing store, its expected image, and every write seen on the port
  word_t mem [MEM_WORDS];
  word_t shadow [MEM_WORDS];
  addr_t wlog_addr [$];
  word_t wlog_data [$];

  // tag model of each cache
  logic ic_valid [NUM_LINES];
  tag_t ic_tag [NUM_LINES];
  logic dc_valid [NUM_LINES];
  tag_t dc_tag [NUM_LINES];

  // read data expected at the next ack
  word_t ic_exp;
  word_t dc_exp;

  wt_cache_subsystem UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic word_t fill_word(input addr_t a);
    return {a ^ 16'h5a3c, ~a} ^ 32'h1234_0000;
  endfunction

  function automatic word_t ref_read(input addr_t a);
    return shadow[a];
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_miss(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  initial begin : memory_model
    int unsigned delay;
    int n;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      tick();
      if (mem_req_o === 1'b1) begin
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay - 1) tick();
        if (mem_we_o) begin
          mem[mem_addr_o] = mem_wdata_o;
          wlog_addr.push_back(mem_addr_o);
          wlog_data.push_back(mem_wdata_o);
        end else begin
          mem_rdata_i = mem[mem_addr_o];
        end
        mem_txn++;
        mem_ack_i = 1'b1;
        n = 0;
        do begin
          tick();
          n++;
        end while (mem_req_o && n < TIMEOUT);
        if (mem_req_o) begin
          $display("timeout waiting for mem_req_o to fall");
          errors++;
        end
        mem_ack_i = 1'b0;
      end
    end
  end

  // read data checked on every rising CPU ack
  initial begin : compare
    logic ic_ack_d;
    logic dc_ack_d;
    ic_ack_d = 1'b0;
    dc_ack_d = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (ic_ack_o === 1'b1 && !ic_ack_d) begin
        check_word("ic_rdata_o", ic_exp, ic_rdata_o);
      end
      if (dc_ack_o === 1'b1 && !dc_ack_d && !dc_we_i) begin
        check_word("dc_rdata_o", dc_exp, dc_rdata_o);
      end
      ic_ack_d = (ic_ack_o === 1'b1);
      dc_ack_d = (dc_ack_o === 1'b1);
    end
  end

  //////////////////////////////
  // CPU drivers
  //////////////////////////////

  task automatic fetch(input addr_t a, input word_t exp);
    logic [IDX_W-1:0] idx;
    tag_t tg;
    logic exp_miss;
    int misses;
    int n;
    idx      = a[IDX_W-1:0];
    tg       = a[ADDR_W-1:IDX_W];
    exp_miss = !(ic_valid[idx] && ic_tag[idx] == tg);
    ic_exp    = exp;
    ic_addr_i = a;
    ic_req_i  = 1'b1;
    misses = 0;
    n = 0;
    do begin
      tick();
      n++;
      if (ic_miss_o) begin
        misses++;
      end
    end while (!ic_ack_o && n < TIMEOUT);
    if (!ic_ack_o) begin
      $display("timeout waiting for ic_ack_o");
      errors++;
    end
    if (misses > 1) begin
      $display("ic_miss_o stayed high for %0d cycles at %0t", misses, $time);
      errors++;
    end
    check_miss("ic_miss_o", exp_miss, misses != 0);
    if (exp_miss) begin
      ic_valid[idx] = 1'b1;
      ic_tag[idx]   = tg;
      exp_txn++;
    end
    ic_req_i = 1'b0;
    n = 0;
    while (ic_ack_o && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (ic_ack_o) begin
      $display("timeout waiting for ic_ack_o to fall");
      errors++;
    end
  endtask

  task automatic load_store(input logic we, input addr_t a, input word_t d);
    logic [IDX_W-1:0] idx;
    tag_t tg;
    logic exp_miss;
    int misses;
    int n;
    int nlog;
    idx      = a[IDX_W-1:0];
    tg       = a[ADDR_W-1:IDX_W];
    exp_miss = !(dc_valid[idx] && dc_tag[idx] == tg);
    nlog     = wlog_addr.size();
    dc_exp     = ref_read(a);
    dc_we_i    = we;
    dc_addr_i  = a;
    dc_wdata_i = d;
    dc_req_i   = 1'b1;
    misses = 0;
    n = 0;
    do begin
      tick();
      n++;
      if (dc_miss_o) begin
        misses++;
      end
    end while (!dc_ack_o && n < TIMEOUT);
    if (!dc_ack_o) begin
      $display("timeout waiting for dc_ack_o");
      errors++;
    end
    if (misses > 1) begin
      $display("dc_miss_o stayed high for %0d cycles at %0t", misses, $time);
      errors++;
    end
    check_miss("dc_miss_o", exp_miss, misses != 0);
    if (we) begin
      // exactly one memory write, same address and data
      exp_txn++;
      if (wlog_addr.size() != nlog + 1) begin
        $display("mismatch at %0t: write count expected %0d got %0d", $time, nlog + 1,
                 wlog_addr.size());
        errors++;
      end else begin
        check_addr("mem_addr_o", a, wlog_addr[nlog]);
        check_word("mem_wdata_o", d, wlog_data[nlog]);
      end
      shadow[a] = d;
    end else if (exp_miss) begin
      dc_valid[idx] = 1'b1;
      dc_tag[idx]   = tg;
      exp_txn++;
    end
    dc_req_i = 1'b0;
    n = 0;
    while (dc_ack_o && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (dc_ack_o) begin
      $display("timeout waiting for dc_ack_o to fall");
      errors++;
    end
  endtask

  task automatic flush_icache();
    ic_flush_i = 1'b1;
    tick();
    ic_flush_i = 1'b0;
    for (int i = 0; i < NUM_LINES; i++) begin
      ic_valid[i] = 1'b0;
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    word_t d;
    word_t old_d;
    grant_e last_grant;
    rst_n_i    = 1'b0;
    ic_flush_i = 1'b0;
    ic_req_i   = 1'b0;
    ic_addr_i  = '0;
    dc_req_i   = 1'b0;
    dc_we_i    = 1'b0;
    dc_addr_i  = '0;
    dc_wdata_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fill_word(addr_t'(i));
      shadow[i] = mem[i];
    end
    for (int i = 0; i < NUM_LINES; i++) begin
      ic_valid[i] = 1'b0;
      dc_valid[i] = 1'b0;
    end
    repeat (5) tick();
    rst_n_i = 1'b1;
    tick();

    // instruction reads, repeat hits, new tag on same index misses
    fetch(16'h0012, ref_read(16'h0012));
    fetch(16'h0012, ref_read(16'h0012));
    fetch(16'h0112, ref_read(16'h0112));
    fetch(16'h0012, ref_read(16'h0012));
    fetch(16'h0013, ref_read(16'h0013));

    // write miss, no allocate, then write hit
    load_store(1'b1, 16'h8003, 32'hcafe_0003);
    load_store(1'b0, 16'h8003, 32'h0);
    load_store(1'b0, 16'h8003, 32'h0);
    load_store(1'b1, 16'h8003, 32'hbeef_1003);
    load_store(1'b0, 16'h8003, 32'h0);

    // read refill and tag conflict
    load_store(1'b0, 16'h8025, 32'h0);
    load_store(1'b0, 16'h8025, 32'h0);
    load_store(1'b0, 16'h8125, 32'h0);
    load_store(1'b0, 16'h8025, 32'h0);

    // icache stays stale until flushed
    old_d = ref_read(16'h0040);
    fetch(16'h0040, old_d);
    load_store(1'b1, 16'h0040, 32'hfeed_0040);
    fetch(16'h0040, old_d);
    flush_icache();
    fetch(16'h0040, ref_read(16'h0040));

    // both sides at once, disjoint address ranges
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      d = $random(seed);
      fork
        fetch({10'h000, r[5:0]}, ref_read({10'h000, r[5:0]}));
        load_store(r[16], {10'h200, r[13:8]}, d);
      join
    end

    repeat (4) tick();
    if (mem_txn != exp_txn) begin
      $display("mismatch at %0t: memory transactions expected %0d got %0d", $time, exp_txn,
               mem_txn);
      errors++;
    end
    last_grant = UUT.u_adapter.last_q;
    $display("errors %0d, memory transactions %0d, writes %0d, last grant %s", errors,
             mem_txn, wlog_addr.size(), last_grant.name());
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
wt_cache_pkg.sv
cache_mem_if.sv
wt_icache.sv
wt_dcache.sv
wt_mem_adapter.sv
wt_cache_subsystem.sv
tb_wt_cache_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_wt_cache_subsystem \
  -f compile.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported errors"
  exit 1
fi
echo "simulation clean"
